// ==== list.f ====
design/exe_pkg.sv
design/reg_file.sv
design/operand_forward.sv
design/exec_lane.sv
design/dual_exe_core.sv
bench/tb_dual_exe.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_dual_exe -f list.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== bench/tb_dual_exe.sv ====
module tb_dual_exe
    import exe_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [5:0] op_table [10] = '{op_add, op_sub, op_and, op_or, op_xor,
                                             op_slt, op_addi, op_ori, 6'h0e, 6'h3c};

    logic clk = 1'b0;
    logic arst_n;
    logic [1:0] issue_valid;
    instr_t [1:0] issue_instr;
    logic [1:0] wb_en;
    logic [1:0][reg_addr_w-1:0] wb_rd;
    logic [1:0][xlen-1:0] wb_data;

    int seed = 32'hbfed0877;
    int wait_cnt;
    logic [xlen-1:0] arch [32];  // model register state
    logic [1:0] ex1_exp_en;
    logic [1:0][reg_addr_w-1:0] ex1_exp_rd;
    logic [1:0][xlen-1:0] ex1_exp_data;
    logic [1:0] exp_en;
    logic [1:0][reg_addr_w-1:0] exp_rd;
    logic [1:0][xlen-1:0] exp_data;

    dual_exe_core #(.lanes(2)) u_dual_exe_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
        abort_run();
    endtask

    task automatic raise_error(input string msg);
        $display("%0t: %s", $time, msg);
        abort_run();
    endtask

    // expected result for the op in bits 31:26
    function automatic logic [31:0] model_alu(input logic [31:0] word, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [5:0]  op;
        logic [15:0] imm;
        op  = word[31:26];
        imm = word[15:0];
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_addi: return a + {{16{imm[15]}}, imm};
            op_ori:  return a | {16'h0000, imm};
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [4:0] draw_reg();
        logic [31:0] r;
        r = $random(seed);
        return {3'b000, r[1:0]};  // r0..r3 only to keep hazards dense
    endfunction

    function automatic logic draw_valid();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0] != 2'b00;
    endfunction

    function automatic logic [31:0] make_instr();
        logic [31:0] w;
        logic [31:0] r;
        int idx;
        idx = $unsigned($random(seed)) % 10;
        r = $random(seed);
        w[31:26] = op_table[idx];
        w[25:21] = draw_reg();
        w[20:16] = draw_reg();
        if (w[31]) begin
            w[15:0] = r[15:0];  // imm view
        end else begin
            w[15:11] = draw_reg();
            w[10:0]  = r[10:0];
        end
        return w;
    endfunction

    task automatic drive_pair();
        logic [1:0]  v;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [4:0]  rd0;
        v[0] = draw_valid();
        v[1] = draw_valid();
        w0 = make_instr();
        w1 = make_instr();
        rd0 = w0[25:21];
        // lane 1 must not read lane 0's rd in the same pair
        if (v[0] && rd0 != 5'd0) begin
            if (w1[20:16] == rd0) w1[20:16] = {3'b000, w1[17:16] + 2'd1};
            if (!w1[31] && w1[15:11] == rd0) w1[15:11] = {3'b000, w1[12:11] + 2'd1};
        end
        issue_valid    <= v;
        issue_instr[0] <= w0;
        issue_instr[1] <= w1;
    endtask

    // reference model sees the pair the DUT captures at this edge
    always @(posedge clk or negedge arst_n) begin : model
        logic [31:0] word;
        logic [4:0]  rd;
        logic [31:0] res;
        if (!arst_n) begin
            for (int r = 0; r < 32; r++) arch[r] = '0;
            ex1_exp_en <= '0;
            exp_en     <= '0;
        end else begin
            for (int l = 0; l < 2; l++) begin
                word = issue_instr[l];
                rd   = word[25:21];
                res  = model_alu(word, arch[word[20:16]], arch[word[15:11]]);
                ex1_exp_en[l]   <= issue_valid[l] && rd != 5'd0;
                ex1_exp_rd[l]   <= rd;
                ex1_exp_data[l] <= res;
                if (issue_valid[l] && rd != 5'd0) arch[rd] = res;  // program order
            end
            exp_en   <= ex1_exp_en;
            exp_rd   <= ex1_exp_rd;
            exp_data <= ex1_exp_data;
        end
    end

    for (genvar l = 0; l < 2; l++) begin : g_check
        assert property (@(posedge clk) disable iff (!arst_n) wb_en[l] == exp_en[l])
            else report_mismatch($sformatf("wb_en[%0d]", l), 32'($sampled(exp_en[l])),
                                 32'($sampled(wb_en[l])));
        assert property (@(posedge clk) disable iff (!arst_n)
                         exp_en[l] |-> wb_rd[l] == exp_rd[l])
            else report_mismatch($sformatf("wb_rd[%0d]", l), 32'($sampled(exp_rd[l])),
                                 32'($sampled(wb_rd[l])));
        assert property (@(posedge clk) disable iff (!arst_n)
                         exp_en[l] |-> wb_data[l] == exp_data[l])
            else report_mismatch($sformatf("wb_data[%0d]", l), $sampled(exp_data[l]),
                                 $sampled(wb_data[l]));
    end

    initial begin
        arst_n      <= 1'b0;
        issue_valid <= '0;
        issue_instr <= '0;
        wait_cnt = 0;
        while (wait_cnt < 5) begin  // reset held low
            @(posedge clk);
            wait_cnt++;
        end
        arst_n <= 1'b1;
        repeat (3) @(posedge clk);  // idle cycles with wb_en low
        for (int c = 0; c < 2000; c++) begin
            @(posedge clk);
            drive_pair();
        end
        @(posedge clk);
        issue_valid <= '0;
        wait_cnt = 0;
        while (ex1_exp_en != 2'b00 || exp_en != 2'b00 || wb_en != 2'b00) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > 10) raise_error("pipeline did not drain after the last issue");
        end
        @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== design/dual_exe_core.sv ====
module dual_exe_core
    import exe_pkg::*;
#(
    parameter int lanes = 2
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [lanes-1:0]                  issue_valid,
    input  instr_t [lanes-1:0]                issue_instr,
    output logic [lanes-1:0]                  wb_en,
    output logic [lanes-1:0][reg_addr_w-1:0]  wb_rd,
    output logic [lanes-1:0][xlen-1:0]        wb_data
);

    logic [2*lanes-1:0][reg_addr_w-1:0]  rs_addr;
    logic [2*lanes-1:0][xlen-1:0]        rf_data;
    logic [2*lanes-1:0][xlen-1:0]        src_data;

    logic [lanes-1:0]                    ex1_en;
    logic [lanes-1:0][reg_addr_w-1:0]    ex1_rd;
    logic [lanes-1:0][xlen-1:0]          ex1_result;
    logic [lanes-1:0]                    ex2_en;
    logic [lanes-1:0][reg_addr_w-1:0]    ex2_rd;
    logic [lanes-1:0][xlen-1:0]          ex2_result;

    reg_file #(.lanes(lanes)) u_reg_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rd_addr (rs_addr),
        .rd_data (rf_data),
        .wr_en   (ex2_en),
        .wr_addr (ex2_rd),
        .wr_data (ex2_result)
    );

    operand_forward #(.lanes(lanes)) u_operand_forward (
        .rs_addr    (rs_addr),
        .rf_data    (rf_data),
        .ex1_en     (ex1_en),
        .ex1_rd     (ex1_rd),
        .ex1_result (ex1_result),
        .ex2_en     (ex2_en),
        .ex2_rd     (ex2_rd),
        .ex2_result (ex2_result),
        .src_data   (src_data)
    );

    for (genvar g = 0; g < lanes; g++) begin : g_lane
        // rk field is read even for imm ops, lane ignores it there
        assign rs_addr[2*g]   = issue_instr[g].r_fmt.rj;
        assign rs_addr[2*g+1] = issue_instr[g].r_fmt.rk;

        exec_lane u_exec_lane (
            .clk         (clk),
            .arst_n      (arst_n),
            .issue_valid (issue_valid[g]),
            .issue_instr (issue_instr[g]),
            .src_a       (src_data[2*g]),
            .src_b       (src_data[2*g+1]),
            .ex1_en      (ex1_en[g]),
            .ex1_rd      (ex1_rd[g]),
            .ex1_result  (ex1_result[g]),
            .ex2_en      (ex2_en[g]),
            .ex2_rd      (ex2_rd[g]),
            .ex2_result  (ex2_result[g])
        );
    end

    assign wb_en   = ex2_en;
    assign wb_rd   = ex2_rd;
    assign wb_data = ex2_result;

endmodule

// ==== design/exec_lane.sv ====
module exec_lane
    import exe_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   issue_valid,
    input  instr_t                 issue_instr,
    input  logic [xlen-1:0]        src_a,
    input  logic [xlen-1:0]        src_b,
    output logic                   ex1_en,
    output logic [reg_addr_w-1:0]  ex1_rd,
    output logic [xlen-1:0]        ex1_result,
    output logic                   ex2_en,
    output logic [reg_addr_w-1:0]  ex2_rd,
    output logic [xlen-1:0]        ex2_result
);

    instr_t          ex1_instr;
    logic [xlen-1:0] ex1_a;
    logic [xlen-1:0] ex1_b;
    logic [5:0]      op;
    logic            use_imm;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] opnd_b;

    // exe1 control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex1_en <= 1'b0;
        end else begin
            ex1_en <= issue_valid && issue_instr.r_fmt.rd != '0;
        end
    end

    // exe1 payload
    always_ff @(posedge clk) begin
        ex1_instr <= issue_instr;
        ex1_a     <= src_a;
        ex1_b     <= src_b;
    end

    assign op      = ex1_instr.r_fmt.op;
    assign use_imm = op[5];
    assign ex1_rd  = ex1_instr.r_fmt.rd;  // same bits in both views

    // ori zero-extends, everything else with an imm sign-extends
    always_comb begin
        if (op == op_ori) begin
            imm_ext = {{(xlen-16){1'b0}}, ex1_instr.i_fmt.imm};
        end else begin
            imm_ext = {{(xlen-16){ex1_instr.i_fmt.imm[15]}}, ex1_instr.i_fmt.imm};
        end
    end

    assign opnd_b = use_imm ? imm_ext : ex1_b;

    always_comb begin
        case (op)
            op_add, op_addi: ex1_result = ex1_a + opnd_b;
            op_sub:          ex1_result = ex1_a - opnd_b;
            op_and:          ex1_result = ex1_a & opnd_b;
            op_or, op_ori:   ex1_result = ex1_a | opnd_b;
            op_xor:          ex1_result = ex1_a ^ opnd_b;
            op_slt: begin
                ex1_result = {{(xlen-1){1'b0}}, $signed(ex1_a) < $signed(opnd_b)};
            end
            default:         ex1_result = '0;  // unknown op
        endcase
    end

    // exe2 control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex2_en <= 1'b0;
        end else begin
            ex2_en <= ex1_en;
        end
    end

    // exe2 payload
    always_ff @(posedge clk) begin
        ex2_rd     <= ex1_rd;
        ex2_result <= ex1_result;
    end

endmodule

// ==== design/operand_forward.sv ====
module operand_forward
    import exe_pkg::*;
#(
    parameter int lanes = 2
) (
    // per lane: rj at 2*l, rk at 2*l+1
    input  logic [2*lanes-1:0][reg_addr_w-1:0]  rs_addr,
    input  logic [2*lanes-1:0][xlen-1:0]        rf_data,
    // exe1 stage, result still combinational
    input  logic [lanes-1:0]                    ex1_en,
    input  logic [lanes-1:0][reg_addr_w-1:0]    ex1_rd,
    input  logic [lanes-1:0][xlen-1:0]          ex1_result,
    // exe2 stage, about to be written back
    input  logic [lanes-1:0]                    ex2_en,
    input  logic [lanes-1:0][reg_addr_w-1:0]    ex2_rd,
    input  logic [lanes-1:0][xlen-1:0]          ex2_result,
    output logic [2*lanes-1:0][xlen-1:0]        src_data
);

    logic [2*lanes-1:0] hit_ex1;  // any exe1 match per source
    logic [2*lanes-1:0] hit_ex2;  // any exe2 match per source
    logic [2*lanes-1:0][xlen-1:0] fwd_ex1;
    logic [2*lanes-1:0][xlen-1:0] fwd_ex2;

    // newest first: exe1 beats exe2, higher lane beats lower lane.
    // lanes are scanned upward so the last match is the youngest.
    always_comb begin
        for (int s = 0; s < 2 * lanes; s++) begin
            hit_ex1[s] = 1'b0;
            hit_ex2[s] = 1'b0;
            fwd_ex1[s] = '0;
            fwd_ex2[s] = '0;
            for (int l = 0; l < lanes; l++) begin
                if (ex1_en[l] && ex1_rd[l] == rs_addr[s]) begin
                    hit_ex1[s] = 1'b1;
                    fwd_ex1[s] = ex1_result[l];
                end
                if (ex2_en[l] && ex2_rd[l] == rs_addr[s]) begin
                    hit_ex2[s] = 1'b1;
                    fwd_ex2[s] = ex2_result[l];
                end
            end
        end
    end

    always_comb begin
        for (int s = 0; s < 2 * lanes; s++) begin
            if (rs_addr[s] == '0) begin
                src_data[s] = rf_data[s];  // r0 never forwards
            end else if (hit_ex1[s]) begin
                src_data[s] = fwd_ex1[s];
            end else if (hit_ex2[s]) begin
                src_data[s] = fwd_ex2[s];
            end else begin
                src_data[s] = rf_data[s];
            end
        end
    end

endmodule

// ==== design/reg_file.sv ====
module reg_file
    import exe_pkg::*;
#(
    parameter int lanes = 2
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [2*lanes-1:0][reg_addr_w-1:0]  rd_addr,
    output logic [2*lanes-1:0][xlen-1:0]        rd_data,
    input  logic [lanes-1:0]                    wr_en,
    input  logic [lanes-1:0][reg_addr_w-1:0]    wr_addr,
    input  logic [lanes-1:0][xlen-1:0]          wr_data
);

    localparam int num_regs = 2 ** reg_addr_w;

    logic [xlen-1:0] regs [num_regs];

    // later lanes are younger, so they overwrite on a shared index
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < num_regs; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < lanes; l++) begin
                if (wr_en[l] && wr_addr[l] != '0) begin
                    regs[wr_addr[l]] <= wr_data[l];
                end
            end
        end
    end

    // two read ports per lane, rj then rk
    always_comb begin
        for (int p = 0; p < 2 * lanes; p++) begin
            if (rd_addr[p] == '0) begin
                rd_data[p] = '0;  // r0 hardwired
            end else begin
                rd_data[p] = regs[rd_addr[p]];
            end
        end
    end

endmodule

// ==== design/exe_pkg.sv ====
package exe_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // one word, two views; op[5] picks the immediate view
    typedef union packed {
        struct packed {
            logic [5:0]            op;
            logic [reg_addr_w-1:0] rd;
            logic [reg_addr_w-1:0] rj;
            logic [reg_addr_w-1:0] rk;
            logic [10:0]           unused;
        } r_fmt;
        struct packed {
            logic [5:0]            op;
            logic [reg_addr_w-1:0] rd;
            logic [reg_addr_w-1:0] rj;
            logic [15:0]           imm;
        } i_fmt;
    } instr_t;

    // register-register ops
    localparam logic [5:0] op_add  = 6'h00;
    localparam logic [5:0] op_sub  = 6'h01;
    localparam logic [5:0] op_and  = 6'h02;
    localparam logic [5:0] op_or   = 6'h03;
    localparam logic [5:0] op_xor  = 6'h04;
    localparam logic [5:0] op_slt  = 6'h05;
    // register-immediate ops
    localparam logic [5:0] op_addi = 6'h20;  // sign-extended imm
    localparam logic [5:0] op_ori  = 6'h21;  // zero-extended imm

endpackage
